// ==== hdl/bpu_cfg_pkg.sv ====
package bpu_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // address and table geometry
    ////////////////////////////////////////////////////////////

    localparam int VADDR_SIZE = 32;
    localparam int UBTB_WAYS  = 8;
    localparam int WAY_IDX_W  = 3;
    localparam int SLOT_NUM   = 2;

    // the tag covers address bits 20 down to 5
    localparam int TAG_SIZE = 16;
    localparam int TAG_LSB  = 5;

    ////////////////////////////////////////////////////////////
    // fetch block and slot fields
    ////////////////////////////////////////////////////////////

    localparam int BLOCK_SIZE = 32;
    localparam int OFFSET_W   = 5;

    // sizes reach BLOCK_SIZE itself, so one bit more than an offset
    localparam int SIZE_W = OFFSET_W + 1;

    // stored low target bits, the address bit 0 is never kept
    localparam int BR_TGT_W  = 12;
    localparam int JMP_TGT_W = 20;

    ////////////////////////////////////////////////////////////
    // replacement
    ////////////////////////////////////////////////////////////

    localparam int LFSR_W = 8;
    localparam logic [LFSR_W-1:0] LFSR_SEED = 8'h5a;

endpackage

// ==== hdl/bpu_types_pkg.sv ====
package bpu_types_pkg;

    import bpu_cfg_pkg::*;

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////

    // how the target high bits relate to the start address high bits
    typedef enum logic [1:0] {
        TAR_FIT = 2'd0,
        TAR_OV  = 2'd1,
        TAR_UN  = 2'd2
    } tar_state_e;

    typedef enum logic [1:0] {
        BR_COND = 2'd0,
        BR_JAL  = 2'd1,
        BR_JALR = 2'd2,
        BR_NONE = 2'd3
    } br_type_e;

    ////////////////////////////////////////////////////////////
    // table entry
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                en;
        logic [OFFSET_W-1:0] offset;
        tar_state_e          tar_state;
        logic [BR_TGT_W-1:0] target;
    } br_slot_t;

    typedef struct packed {
        logic [JMP_TGT_W-BR_TGT_W-1:0] pad;
        logic [BR_TGT_W-1:0]           target;
    } tail_br_view_t;

    // the tail target word, read through the view that br_type selects
    typedef union packed {
        tail_br_view_t        br;
        logic [JMP_TGT_W-1:0] jmp;
    } tail_tgt_u;

    typedef struct packed {
        logic                en;
        br_type_e            br_type;
        logic [OFFSET_W-1:0] offset;
        tar_state_e          tar_state;
        tail_tgt_u           tgt;
    } tail_slot_t;

    typedef struct packed {
        logic                valid;
        logic [TAG_SIZE-1:0] tag;
        br_slot_t            slot0;
        tail_slot_t          tail;
        logic [SIZE_W-1:0]   fth_size;
    } btb_entry_t;

    // slot 0 is the conditional slot, slot 1 the tail
    typedef logic [SLOT_NUM-1:0][1:0] ctr_pair_t;

    ////////////////////////////////////////////////////////////
    // port payloads
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [VADDR_SIZE-1:0] start_addr;
    } fetch_req_t;

    typedef struct packed {
        logic [VADDR_SIZE-1:0] start_addr;
        logic                  hit;
        logic                  taken;
        logic [SLOT_NUM-1:0]   slot_taken;
        br_type_e              br_type;
        logic [SIZE_W-1:0]     size;
        logic [VADDR_SIZE-1:0] target;
        ctr_pair_t             ctr;
    } ubtb_pred_t;

    typedef struct packed {
        logic [VADDR_SIZE-1:0] start_addr;
        btb_entry_t            entry;
        ctr_pair_t             old_ctr;
        logic [SLOT_NUM-1:0]   real_taken;
    } ubtb_update_t;

endpackage

// ==== hdl/fetch_req_stage.sv ====
`timescale 1ns/100ps

module fetch_req_stage
    import bpu_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_valid,
    input  fetch_req_t req,
    output logic       req_ready,
    output logic       cur_valid,
    output fetch_req_t cur_req,
    input  logic       in_ready
);

    logic       full_q;
    fetch_req_t req_q;
    logic       accept;

    // a new request may enter while the held one moves on
    assign req_ready = !full_q || in_ready;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (accept) begin
            full_q <= 1'b1;
        end else if (in_ready) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    assign cur_valid = full_q;
    assign cur_req   = req_q;

endmodule

// ==== hdl/ubtb_replace.sv ====
`timescale 1ns/100ps

module ubtb_replace
    import bpu_cfg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 advance,
    output logic [WAY_IDX_W-1:0] victim
);

    // feedback taps for x^8 + x^6 + x^5 + x^4 + 1
    localparam logic [LFSR_W-1:0] TAPS = 8'hb8;

    logic [LFSR_W-1:0] lfsr_q;
    logic [LFSR_W-1:0] lfsr_next;

    // galois form, shifting right with the feedback from bit 0
    always_comb begin
        lfsr_next = {1'b0, lfsr_q[LFSR_W-1:1]};
        if (lfsr_q[0]) begin
            lfsr_next = lfsr_next ^ TAPS;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= LFSR_SEED;
        end else if (advance) begin
            lfsr_q <= lfsr_next;
        end
    end

    assign victim = lfsr_q[WAY_IDX_W-1:0];

endmodule

// ==== hdl/ubtb.sv ====
`timescale 1ns/100ps

module ubtb
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         cur_valid,
    input  fetch_req_t   cur_req,
    output ubtb_pred_t   lookup_pred,
    input  logic         upd_valid,
    input  ubtb_update_t upd
);

    function automatic logic [TAG_SIZE-1:0] addr_tag(input logic [VADDR_SIZE-1:0] addr);
        return addr[TAG_LSB +: TAG_SIZE];
    endfunction

    // offset plus one in 2-byte units, returned in bytes
    function automatic logic [SIZE_W-1:0] slot_size(input logic [OFFSET_W-1:0] offset);
        logic [SIZE_W-2:0] units;
        units = {1'b0, offset[OFFSET_W-1:1]} + 1'b1;
        return {units, 1'b0};
    endfunction

    function automatic logic [VADDR_SIZE-1:0] rebuild_target(
        input logic [VADDR_SIZE-1:0] start,
        input tar_state_e            st,
        input logic [JMP_TGT_W-1:0]  low,
        input int unsigned           low_w
    );
        logic [VADDR_SIZE-1:0] high;
        high = start >> (low_w + 1);
        if (st == TAR_OV) begin
            high = high + VADDR_SIZE'(1);
        end else if (st == TAR_UN) begin
            high = high - VADDR_SIZE'(1);
        end
        return (high << (low_w + 1)) | (VADDR_SIZE'(low) << 1);
    endfunction

    function automatic logic [1:0] sat_ctr(input logic [1:0] ctr, input logic taken);
        if (taken) begin
            return (ctr == 2'd3) ? ctr : ctr + 2'd1;
        end
        return (ctr == 2'd0) ? ctr : ctr - 2'd1;
    endfunction

    btb_entry_t           entries [UBTB_WAYS];
    ctr_pair_t            ctrs [UBTB_WAYS];
    logic [UBTB_WAYS-1:0] valid_q;

    logic [VADDR_SIZE-1:0] start;
    logic [UBTB_WAYS-1:0]  lookup_hits;
    logic [UBTB_WAYS-1:0]  upd_hits;
    logic [WAY_IDX_W-1:0]  lookup_idx;
    logic [WAY_IDX_W-1:0]  upd_idx;
    logic [WAY_IDX_W-1:0]  victim;
    logic [WAY_IDX_W-1:0]  write_idx;
    logic                  hit;
    logic                  upd_hit;
    btb_entry_t            lk_entry;
    ctr_pair_t             lk_ctr;
    logic [SLOT_NUM-1:0]   br_taken;
    logic                  tail_jmp;
    logic                  pick_tail;
    logic [VADDR_SIZE-1:0] slot0_tgt;
    logic [VADDR_SIZE-1:0] tail_br_tgt;
    logic [VADDR_SIZE-1:0] jmp_tgt;
    btb_entry_t            wr_entry;
    ctr_pair_t             wr_ctr;

    assign start = cur_req.start_addr;

    always_comb begin
        lookup_idx = '0;
        upd_idx    = '0;
        for (int i = 0; i < UBTB_WAYS; i++) begin
            lookup_hits[i] = valid_q[i] && (entries[i].tag == addr_tag(start));
            upd_hits[i]    = valid_q[i] && (entries[i].tag == addr_tag(upd.start_addr));
            if (lookup_hits[i]) begin
                lookup_idx = WAY_IDX_W'(i);
            end
            if (upd_hits[i]) begin
                upd_idx = WAY_IDX_W'(i);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////

    assign hit      = cur_valid && (|lookup_hits);
    assign lk_entry = entries[lookup_idx];
    assign lk_ctr   = ctrs[lookup_idx];

    assign br_taken[0] = lk_entry.slot0.en && lk_ctr[0][1];
    assign br_taken[1] = lk_entry.tail.en && (lk_entry.tail.br_type == BR_COND) && lk_ctr[1][1];
    assign tail_jmp    = lk_entry.tail.en &&
                         (lk_entry.tail.br_type == BR_JAL || lk_entry.tail.br_type == BR_JALR);

    // slot 0 keeps a tie on offset
    assign pick_tail = br_taken[1] &&
                       (!br_taken[0] || (lk_entry.tail.offset < lk_entry.slot0.offset));

    assign slot0_tgt = rebuild_target(start, lk_entry.slot0.tar_state,
                                      JMP_TGT_W'(lk_entry.slot0.target), BR_TGT_W);
    assign tail_br_tgt = rebuild_target(start, lk_entry.tail.tar_state,
                                        JMP_TGT_W'(lk_entry.tail.tgt.br.target), BR_TGT_W);
    assign jmp_tgt = rebuild_target(start, lk_entry.tail.tar_state,
                                    lk_entry.tail.tgt.jmp, JMP_TGT_W);

    always_comb begin
        lookup_pred.start_addr = start;
        lookup_pred.hit        = hit;
        lookup_pred.taken      = 1'b0;
        lookup_pred.slot_taken = '0;
        lookup_pred.br_type    = BR_NONE;
        lookup_pred.size       = SIZE_W'(BLOCK_SIZE);
        lookup_pred.target     = start + VADDR_SIZE'(BLOCK_SIZE);
        lookup_pred.ctr        = hit ? lk_ctr : '0;
        if (hit) begin
            if (br_taken[0] && !pick_tail) begin
                lookup_pred.taken      = 1'b1;
                lookup_pred.slot_taken = 2'b01;
                lookup_pred.br_type    = BR_COND;
                lookup_pred.size       = slot_size(lk_entry.slot0.offset);
                lookup_pred.target     = slot0_tgt;
            end else if (pick_tail) begin
                lookup_pred.taken      = 1'b1;
                lookup_pred.slot_taken = 2'b10;
                lookup_pred.br_type    = BR_COND;
                lookup_pred.size       = slot_size(lk_entry.tail.offset);
                lookup_pred.target     = tail_br_tgt;
            end else if (tail_jmp) begin
                // a jump in the tail is always taken and reports as the tail slot
                lookup_pred.taken      = 1'b1;
                lookup_pred.slot_taken = 2'b10;
                lookup_pred.br_type    = lk_entry.tail.br_type;
                lookup_pred.size       = slot_size(lk_entry.tail.offset);
                lookup_pred.target     = jmp_tgt;
            end else begin
                lookup_pred.size   = lk_entry.fth_size;
                lookup_pred.target = start + VADDR_SIZE'(lk_entry.fth_size);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // update
    ////////////////////////////////////////////////////////////

    assign upd_hit   = |upd_hits;
    assign write_idx = upd_hit ? upd_idx : victim;

    // the stored tag always comes from the update address
    always_comb begin
        wr_entry       = upd.entry;
        wr_entry.valid = 1'b1;
        wr_entry.tag   = addr_tag(upd.start_addr);
        for (int s = 0; s < SLOT_NUM; s++) begin
            wr_ctr[s] = sat_ctr(upd.old_ctr[s], upd.real_taken[s]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            ctrs    <= '{default: '0};
        end else if (upd_valid) begin
            valid_q[write_idx] <= 1'b1;
            ctrs[write_idx]    <= wr_ctr;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_valid) begin
            entries[write_idx] <= wr_entry;
        end
    end

    ubtb_replace i_replace (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (upd_valid && !upd_hit),
        .victim  (victim)
    );

endmodule

// ==== hdl/pred_out_queue.sv ====
`timescale 1ns/100ps

module pred_out_queue
    import bpu_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  ubtb_pred_t in_pred,
    output logic       in_ready,
    output logic       pred_valid,
    output ubtb_pred_t pred,
    input  logic       pred_ready
);

    ubtb_pred_t mem [2];
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] count_q;
    logic       push;
    logic       pop;

    assign in_ready   = count_q < 2'd2;
    assign pred_valid = count_q != 2'd0;
    assign pred       = mem[rd_ptr_q];

    assign push = in_valid && in_ready;
    assign pop  = pred_valid && pred_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= !wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= !rd_ptr_q;
            end
            if (push && !pop) begin
                count_q <= count_q + 2'd1;
            end else if (pop && !push) begin
                count_q <= count_q - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= in_pred;
        end
    end

endmodule

// ==== hdl/ubtb_top.sv ====
`timescale 1ns/100ps

module ubtb_top
    import bpu_types_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         req_valid,
    input  fetch_req_t   req,
    output logic         req_ready,
    output logic         pred_valid,
    output ubtb_pred_t   pred,
    input  logic         pred_ready,
    input  logic         upd_valid,
    input  ubtb_update_t upd
);

    logic       cur_valid;
    fetch_req_t cur_req;
    ubtb_pred_t lookup_pred;
    logic       in_ready;

    fetch_req_stage i_req_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .cur_valid (cur_valid),
        .cur_req   (cur_req),
        .in_ready  (in_ready)
    );

    ubtb i_ubtb (
        .clk         (clk),
        .rst_n       (rst_n),
        .cur_valid   (cur_valid),
        .cur_req     (cur_req),
        .lookup_pred (lookup_pred),
        .upd_valid   (upd_valid),
        .upd         (upd)
    );

    pred_out_queue i_out_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (cur_valid),
        .in_pred    (lookup_pred),
        .in_ready   (in_ready),
        .pred_valid (pred_valid),
        .pred       (pred),
        .pred_ready (pred_ready)
    );

endmodule

// ==== verification/ubtb_assert.sv ====
`timescale 1ns/100ps

module ubtb_assert
    import bpu_types_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       cur_valid,
    input fetch_req_t cur_req,
    input logic       in_ready,
    input logic       pred_valid,
    input logic       pred_ready,
    input ubtb_pred_t pred
);

    // a stalled prediction keeps its valid and its content
    pred_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        pred_valid && !pred_ready |=> pred_valid && $stable(pred)
    ) else $error("prediction changed while stalled");

    // nothing is in flight in the first cycle out of reset
    reset_empty: assert property (
        @(posedge clk) $rose(rst_n) |-> !pred_valid && !cur_valid
    ) else $error("pipeline not empty after reset");

    // a blocked stage keeps its item, so no new request was taken in
    no_accept_when_blocked: assert property (
        @(posedge clk) disable iff (!rst_n)
        cur_valid && !in_ready |=> cur_valid && $stable(cur_req)
    ) else $error("request accepted into a blocked input stage");

endmodule

// ==== verification/ubtb_tb.sv ====
`timescale 1ns/100ps

module ubtb_tb
    import bpu_cfg_pkg::*, bpu_types_pkg::*;
;

    localparam int N_REQ = 300;
    localparam logic [1:0] M_MISS = 2'd0;
    localparam logic [1:0] M_EITHER = 2'd1;
    localparam logic [1:0] M_HIT = 2'd2;

    // hit_p is the answer if the tag is still in the table, miss_p if it was evicted
    typedef struct packed {
        ubtb_pred_t hit_p;
        ubtb_pred_t miss_p;
        logic [1:0] mode;
    } exp_t;

    logic         clk;
    logic         rst_n;
    logic         req_valid;
    fetch_req_t   req;
    logic         req_ready;
    logic         pred_valid;
    ubtb_pred_t   pred;
    logic         pred_ready;
    logic         upd_valid;
    ubtb_update_t upd;

    exp_t                  exp_q[$];
    exp_t                  got_x;
    btb_entry_t            m_entry[logic [TAG_SIZE-1:0]];
    ctr_pair_t             m_ctr[logic [TAG_SIZE-1:0]];
    logic [VADDR_SIZE-1:0] m_addr[logic [TAG_SIZE-1:0]];
    // tags known to be in the table since the last write that could evict
    logic                  m_sure[logic [TAG_SIZE-1:0]];
    logic [VADDR_SIZE-1:0] known[$];
    logic                  bp_on;
    int                    probe_hits;
    btb_entry_t            e;

    ubtb_top i_ubtb_top (.*);

    bind ubtb_top ubtb_assert i_ubtb_assert (
        .clk(clk), .rst_n(rst_n), .cur_valid(cur_valid), .cur_req(cur_req),
        .in_ready(in_ready), .pred_valid(pred_valid), .pred_ready(pred_ready),
        .pred(pred)
    );

    always #50 clk = !clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t ns: pred.%s got %h expected %h", $time, name, got, exp);
            stop_run("prediction mismatch");
        end
    endtask

    function automatic logic [TAG_SIZE-1:0] tag_of(input logic [VADDR_SIZE-1:0] a);
        return a[TAG_LSB +: TAG_SIZE];
    endfunction

    function automatic logic [1:0] sat(input logic [1:0] c, input logic t);
        if (t) begin
            return (c == 2'd3) ? 2'd3 : c + 2'd1;
        end
        return (c == 2'd0) ? 2'd0 : c - 2'd1;
    endfunction

    // high part of the start address stepped by tar_state, low bits stored in 2-byte units
    function automatic logic [31:0] rebuild(input logic [31:0] a, input tar_state_e st,
                                            input logic [31:0] low, input int w);
        logic [31:0] step;
        logic [31:0] base;
        step = 32'd1 << (w + 1);
        base = a & ~(step - 32'd1);
        if (st == TAR_OV) begin
            base = base + step;
        end else if (st == TAR_UN) begin
            base = base - step;
        end
        return base | (low << 1);
    endfunction

    function automatic logic [SIZE_W-1:0] sz(input logic [OFFSET_W-1:0] off);
        return SIZE_W'(((off >> 1) + 1) * 2);
    endfunction

    function automatic ubtb_pred_t exp_miss(input logic [31:0] a);
        ubtb_pred_t p;
        p            = '0;
        p.start_addr = a;
        p.br_type    = BR_NONE;
        p.size       = SIZE_W'(BLOCK_SIZE);
        p.target     = a + 32'(BLOCK_SIZE);
        return p;
    endfunction

    function automatic ubtb_pred_t exp_hit(input logic [31:0] a, input btb_entry_t x,
                                           input ctr_pair_t c);
        ubtb_pred_t p;
        logic       t0;
        logic       t1;
        p        = exp_miss(a);
        p.hit    = 1'b1;
        p.ctr    = c;
        p.size   = x.fth_size;
        p.target = a + 32'(x.fth_size);
        t0 = x.slot0.en && c[0] >= 2'd2;
        t1 = x.tail.en && x.tail.br_type == BR_COND && c[1] >= 2'd2;
        if (t0 && (!t1 || x.slot0.offset <= x.tail.offset)) begin
            p.taken = 1'b1;
            p.slot_taken = 2'b01;
            p.br_type = BR_COND;
            p.size = sz(x.slot0.offset);
            p.target = rebuild(a, x.slot0.tar_state, 32'(x.slot0.target), BR_TGT_W);
        end else if (t1) begin
            p.taken = 1'b1;
            p.slot_taken = 2'b10;
            p.br_type = BR_COND;
            p.size = sz(x.tail.offset);
            p.target = rebuild(a, x.tail.tar_state, 32'(x.tail.tgt.br.target), BR_TGT_W);
        end else if (x.tail.en && (x.tail.br_type == BR_JAL || x.tail.br_type == BR_JALR)) begin
            p.taken = 1'b1;
            p.slot_taken = 2'b10;
            p.br_type = x.tail.br_type;
            p.size = sz(x.tail.offset);
            p.target = rebuild(a, x.tail.tar_state, 32'(x.tail.tgt.jmp), JMP_TGT_W);
        end
        return p;
    endfunction

    function automatic btb_entry_t mk(input logic [31:0] a, input logic s0en,
            input logic [4:0] s0off, input tar_state_e s0st, input logic [11:0] s0tgt,
            input logic ten, input br_type_e tty, input logic [4:0] toff,
            input tar_state_e tst, input logic [19:0] ttgt, input logic [5:0] fth);
        btb_entry_t x;
        x = '0;
        x.valid = 1'b1;
        x.tag = tag_of(a);
        x.slot0.en = s0en;
        x.slot0.offset = s0off;
        x.slot0.tar_state = s0st;
        x.slot0.target = s0tgt;
        x.tail.en = ten;
        x.tail.br_type = tty;
        x.tail.offset = toff;
        x.tail.tar_state = tst;
        if (tty == BR_COND) begin
            x.tail.tgt.br.target = ttgt[BR_TGT_W-1:0];
        end else begin
            x.tail.tgt.jmp = ttgt;
        end
        x.fth_size = fth;
        return x;
    endfunction

    task automatic send_req(input logic [31:0] a);
        exp_t x;
        logic go;
        logic [TAG_SIZE-1:0] t;
        req_valid = 1'b1;
        req.start_addr = a;
        go = 1'b0;
        while (!go) begin
            @(negedge clk);
            go = req_ready;
            @(posedge clk);
        end
        t = tag_of(a);
        x.miss_p = exp_miss(a);
        x.hit_p = x.miss_p;
        x.mode = M_MISS;
        if (m_entry.exists(t)) begin
            x.hit_p = exp_hit(a, m_entry[t], m_ctr[t]);
            x.mode = m_sure.exists(t) ? M_HIT : M_EITHER;
        end
        exp_q.push_back(x);
        #10;
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        #10;
    endtask

    task automatic do_update(input logic [31:0] a, input btb_entry_t x, input logic [1:0] rt);
        ctr_pair_t old;
        ctr_pair_t nc;
        logic [TAG_SIZE-1:0] t;
        drain();
        t = tag_of(a);
        old = m_ctr.exists(t) ? m_ctr[t] : '0;
        upd.start_addr = a;
        upd.entry = x;
        upd.old_ctr = old;
        upd.real_taken = rt;
        upd_valid = 1'b1;
        @(posedge clk);
        #10;
        upd_valid = 1'b0;
        nc[0] = sat(old[0], rt[0]);
        nc[1] = sat(old[1], rt[1]);
        m_entry[t] = x;
        m_ctr[t] = nc;
        m_addr[t] = a;
        // a write to a tag not known to be held may land on any way
        if (!m_sure.exists(t)) begin
            m_sure.delete();
        end
        m_sure[t] = 1'b1;
    endtask

    // looks up every tag the model holds and drops those the table has lost
    task automatic probe_all();
        logic [31:0] addrs[$];
        drain();
        probe_hits = 0;
        foreach (m_addr[t]) begin
            addrs.push_back(m_addr[t]);
        end
        foreach (addrs[i]) begin
            send_req(addrs[i]);
        end
        drain();
        assert (probe_hits <= UBTB_WAYS)
            else stop_run("table holds more entries than it has ways");
    endtask

    ////////////////////////////////////////////////////////////
    // checking of each prediction transfer
    ////////////////////////////////////////////////////////////

    initial begin
        forever begin
            @(negedge clk);
            if (pred_valid) begin
                assert (exp_q.size() != 0) else stop_run("pred_valid high with nothing expected");
                if (pred_ready) begin
                    got_x = exp_q.pop_front();
                    check_pred(got_x);
                end
            end
        end
    end

    task automatic check_pred(input exp_t x);
        ubtb_pred_t p;
        logic [TAG_SIZE-1:0] t;
        p = (x.mode == M_HIT || (x.mode == M_EITHER && pred.hit)) ? x.hit_p : x.miss_p;
        check_field("start_addr", pred.start_addr, p.start_addr);
        check_field("hit", 32'(pred.hit), 32'(p.hit));
        check_field("taken", 32'(pred.taken), 32'(p.taken));
        check_field("slot_taken", 32'(pred.slot_taken), 32'(p.slot_taken));
        check_field("br_type", 32'(pred.br_type), 32'(p.br_type));
        check_field("size", 32'(pred.size), 32'(p.size));
        check_field("target", pred.target, p.target);
        check_field("ctr", 32'(pred.ctr), 32'(p.ctr));
        t = tag_of(pred.start_addr);
        if (pred.hit) begin
            probe_hits++;
            m_sure[t] = 1'b1;
        end else if (x.mode == M_EITHER) begin
            m_entry.delete(t);
            m_ctr.delete(t);
            m_addr.delete(t);
        end
    endtask

    initial begin
        pred_ready = 1'b0;
        forever begin
            @(posedge clk);
            #10;
            pred_ready = bp_on ? 1'(($urandom & 1) != 0) : 1'b1;
        end
    end

    initial begin
        repeat (N_REQ * 20 + 200) @(posedge clk);
        $display("run timed out with %0d predictions outstanding", exp_q.size());
        stop_run("watchdog expired");
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h41dd));
        clk = 1'b0;
        rst_n = 1'b0;
        req_valid = 1'b0;
        req = '0;
        upd_valid = 1'b0;
        upd = '0;
        bp_on = 1'b0;
        probe_hits = 0;
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b1;

        // empty table, every lookup misses
        repeat (4) send_req($urandom);
        drain();

        // two conditional branches, lower offset wins, then tail alone with overflow
        e = mk(32'h0001_0040, 1, 6, TAR_FIT, 12'h155, 1, BR_COND, 10, TAR_OV, 20'h0aa, 20);
        do_update(32'h0001_0040, e, 2'b11);
        do_update(32'h0001_0040, e, 2'b11);
        send_req(32'h0001_0040);
        do_update(32'h0001_0040, e, 2'b10);
        send_req(32'h0001_0044);
        e = mk(32'h0003_2100, 1, 12, TAR_UN, 12'h7f0, 1, BR_COND, 4, TAR_FIT, 20'h123, 32);
        do_update(32'h0003_2100, e, 2'b11);
        do_update(32'h0003_2100, e, 2'b11);
        send_req(32'h0003_2100);
        e = mk(32'h0005_4400, 1, 2, TAR_UN, 12'h00e, 0, BR_NONE, 0, TAR_FIT, 20'h0, 16);
        do_update(32'h0005_4400, e, 2'b01);
        do_update(32'h0005_4400, e, 2'b01);
        send_req(32'h0005_4400);

        // jumps in the tail and fall-through
        e = mk(32'h0007_8020, 1, 8, TAR_FIT, 12'h010, 1, BR_JAL, 14, TAR_OV, 20'h12345, 32);
        do_update(32'h0007_8020, e, 2'b00);
        send_req(32'h0007_8020);
        e = mk(32'h0009_a000, 0, 0, TAR_FIT, 12'h0, 1, BR_JALR, 30, TAR_UN, 20'h0beef, 32);
        do_update(32'h0009_a000, e, 2'b00);
        send_req(32'h0009_a000);
        e = mk(32'h000b_c0e0, 1, 6, TAR_FIT, 12'h003, 1, BR_COND, 20, TAR_FIT, 20'h4, 24);
        do_update(32'h000b_c0e0, e, 2'b01);
        send_req(32'h000b_c0e0);

        // counter training with saturation at both ends
        e = mk(32'h000d_0000, 1, 4, TAR_FIT, 12'h044, 1, BR_COND, 8, TAR_OV, 20'h88, 28);
        repeat (5) do_update(32'h000d_0000, e, 2'b11);
        send_req(32'h000d_0000);
        repeat (2) do_update(32'h000d_0000, e, 2'b00);
        send_req(32'h000d_0000);
        repeat (3) do_update(32'h000d_0000, e, 2'b00);
        send_req(32'h000d_0000);
        repeat (2) do_update(32'h000d_0000, e, 2'b01);
        send_req(32'h000d_0000);

        // a re-update hits its own way and must not evict anything
        probe_all();
        do_update(32'h000d_0000, e, 2'b10);
        probe_all();
        for (int i = 0; i < 9; i++) begin
            e = mk(32'h0050_0000 + (i << 5), 1, 5'(i * 2), TAR_FIT, 12'(i), 0, BR_NONE, 0,
                   TAR_FIT, 20'h0, 6'(i * 2 + 2));
            do_update(32'h0050_0000 + (i << 5), e, 2'b01);
        end
        probe_all();

        // back-pressure with back-to-back requests
        foreach (m_addr[t]) begin
            known.push_back(m_addr[t]);
        end
        bp_on = 1'b1;
        for (int i = 0; i < 150; i++) begin
            if (($urandom & 1) != 0) begin
                send_req(known[$urandom % known.size()] + 32'(($urandom % 4) * 2));
            end else begin
                send_req($urandom);
            end
        end
        drain();
        bp_on = 1'b0;
        drain();

        if (exp_q.size() != 0 || pred_valid) begin
            stop_run("predictions outstanding or unexpected at the end of the run");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
hdl/bpu_cfg_pkg.sv
hdl/bpu_types_pkg.sv
hdl/fetch_req_stage.sv
hdl/ubtb_replace.sv
hdl/ubtb.sv
hdl/pred_out_queue.sv
hdl/ubtb_top.sv
verification/ubtb_assert.sv
verification/ubtb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the uBTB testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module ubtb_tb \
    -f filelist.f -o sim_ubtb \
    && ./obj_dir/sim_ubtb \
    || exit 1
